//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_WORD    = 3'b010; // lw and sw only
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_BLTU    = 3'b110;
    localparam funct3_t F3_BGEU    = 3'b111;

    localparam funct7_t F7_ALT = 7'b0100000; // sub and sra

    localparam int REG_COUNT       = 32;
    localparam int DMEM_WORDS      = 256;
    localparam int DMEM_INDEX_BITS = $clog2(DMEM_WORDS);

    typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, WRITEBACK} cpuState_e;

    // Compare codes only drive the condition flag
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, EQ, NE, GE, GEU
    } aluOp_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} immKind_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_TARGET, PC_ALU} pcSel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel_e;

    typedef struct packed {
        logic     irWrite;
        logic     operandLoad;
        logic     aluSrcImm;
        aluOp_e   aluOp;
        immKind_e immKind;
        logic     resultLoad;
        logic     memWrite;
        logic     regWrite;
        wbSel_e   wbSel;
        logic     pcWrite;
        pcSel_e   pcSel;
    } control_t;

    typedef struct packed {
        logic     enable;
        regAddr_t addr;
        word_t    data;
    } regWrite_t;

endpackage

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  word_t  a,
    input  word_t  b,
    input  aluOp_e op,
    output word_t  result,
    output logic   condition
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {31'b0, lessSigned};
            SLTU:    result = {31'b0, lessUnsigned};
            SLL:     result = a << b[4:0];
            SRL:     result = a >> b[4:0];
            SRA:     result = word_t'($signed(a) >>> b[4:0]);
            default: result = '0; // Result unused by compares
        endcase
    end

    always_comb begin
        case (op)
            EQ:      condition = (a == b);
            NE:      condition = (a != b);
            SLT:     condition = lessSigned;
            SLTU:    condition = lessUnsigned;
            GE:      condition = !lessSigned;
            GEU:     condition = !lessUnsigned;
            default: condition = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import cpuPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  regAddr_t  rs1Addr,
    input  regAddr_t  rs2Addr,
    output word_t     rs1Data,
    output word_t     rs2Data,
    input  regWrite_t wr
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.enable && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // x0 stays zero because the write port skips it
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    assert property (@(posedge clk) disable iff (reset) (rs1Addr == '0) |-> rs1Data == '0);
    assert property (@(posedge clk) disable iff (reset) (rs2Addr == '0) |-> rs2Data == '0);

endmodule

`default_nettype wire

//--- source/immediateGen.sv
`timescale 1ns/1ps
`default_nettype none

module immediateGen
    import cpuPkg::*;
(
    input  word_t    instr,
    input  immKind_e kind,
    output word_t    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (kind)
            IMM_I:   imm = {{20{sign}}, instr[31:20]}; // Shift amounts pass through too
            IMM_S:   imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

endmodule

`default_nettype wire

//--- source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory
    import cpuPkg::*;
(
    input  logic  clk,
    input  word_t addr,
    input  word_t wData,
    input  logic  write,
    output word_t rData
);

    word_t mem [DMEM_WORDS];
    logic [DMEM_INDEX_BITS-1:0] index;

    assign index = addr[DMEM_INDEX_BITS+1:2]; // Word index

    always_ff @(posedge clk) begin
        if (write) begin
            mem[index] <= wData;
        end
        rData <= mem[index];
    end

endmodule

`default_nettype wire

//--- control/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  logic     branchTaken,
    output control_t ctrl,
    output word_t    retired
);

    cpuState_e state;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    aluOp_e    arithOp;   // Shared by register and immediate forms
    aluOp_e    branchOp;
    logic      branchOk;
    aluOp_e    aluOp;
    logic      aluSrcImm;
    immKind_e  immKind;
    wbSel_e    wbSel;
    pcSel_e    nextPc;
    logic      writesRd;
    logic      writesMem;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            retired <= '0;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= EXECUTE;
                EXECUTE: state <= WRITEBACK;
                default: state <= FETCH;
            endcase
            if (state == WRITEBACK) begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_comb begin
        case (funct3)
            F3_ADD_SUB: arithOp = (opcode == OP_REG && funct7 == F7_ALT) ? SUB : ADD;
            F3_SLL:     arithOp = SLL;
            F3_SLT:     arithOp = SLT;
            F3_SLTU:    arithOp = SLTU;
            F3_XOR:     arithOp = XOR;
            F3_SRL_SRA: arithOp = (funct7 == F7_ALT) ? SRA : SRL;
            F3_OR:      arithOp = OR;
            default:    arithOp = AND;
        endcase
    end

    always_comb begin
        branchOk = 1'b1;
        case (funct3)
            F3_BEQ:  branchOp = EQ;
            F3_BNE:  branchOp = NE;
            F3_BLT:  branchOp = SLT;
            F3_BGE:  branchOp = GE;
            F3_BLTU: branchOp = SLTU;
            F3_BGEU: branchOp = GEU;
            default: begin
                branchOp = EQ;
                branchOk = 1'b0; // Reserved encodings fall through as no-op
            end
        endcase
    end

    always_comb begin
        aluOp     = ADD;
        aluSrcImm = 1'b0;
        immKind   = IMM_I;
        wbSel     = WB_ALU;
        nextPc    = PC_PLUS4;
        writesRd  = 1'b0;
        writesMem = 1'b0;
        case (opcode)
            OP_REG: begin
                aluOp    = arithOp;
                writesRd = 1'b1;
            end
            OP_IMM: begin
                aluOp     = arithOp;
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            OP_LOAD: begin
                aluSrcImm = 1'b1;
                wbSel     = WB_MEM;
                writesRd  = (funct3 == F3_WORD);
            end
            OP_STORE: begin
                aluSrcImm = 1'b1;
                immKind   = IMM_S;
                writesMem = (funct3 == F3_WORD);
            end
            OP_BRANCH: begin
                aluOp   = branchOp;
                immKind = IMM_B;
                if (branchOk && branchTaken) begin
                    nextPc = PC_TARGET;
                end
            end
            OP_JAL: begin
                immKind  = IMM_J;
                wbSel    = WB_PC4;
                nextPc   = PC_TARGET;
                writesRd = 1'b1;
            end
            OP_JALR: begin
                aluSrcImm = 1'b1;
                wbSel     = WB_PC4;
                nextPc    = PC_ALU; // rs1 + imm from the result register
                writesRd  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        ctrl.irWrite     = (state == FETCH);
        ctrl.operandLoad = (state == DECODE);
        ctrl.aluSrcImm   = aluSrcImm;
        ctrl.aluOp       = aluOp;
        ctrl.immKind     = immKind;
        ctrl.resultLoad  = (state == EXECUTE);
        ctrl.memWrite    = (state == EXECUTE) && writesMem;
        ctrl.regWrite    = (state == WRITEBACK) && writesRd;
        ctrl.wbSel       = wbSel;
        ctrl.pcWrite     = (state == WRITEBACK);
        ctrl.pcSel       = nextPc;
    end

    // Write strobes only in the cycle after EXECUTE
    assert property (@(posedge clk) disable iff (reset)
        (ctrl.regWrite || ctrl.pcWrite) |-> $past(ctrl.resultLoad));
    assert property (@(posedge clk) disable iff (reset)
        ctrl.memWrite |-> $past(ctrl.operandLoad));
    assert property (@(posedge clk) disable iff (reset)
        ctrl.memWrite |=> ctrl.pcWrite && !ctrl.regWrite);

endmodule

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import cpuPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  control_t  ctrl,
    input  word_t     instrData,
    output word_t     instrAddr,
    output word_t     instr,
    output logic      branchTaken,
    output word_t     memAddr,
    output word_t     memWData,
    output logic      memWrite,
    input  word_t     memRData,
    output regWrite_t wbPort
);

    word_t pc;
    word_t ir;
    word_t rs1Reg;
    word_t rs2Reg;
    word_t immReg;
    word_t resultReg;
    word_t rs1Data;
    word_t rs2Data;
    word_t imm;
    word_t aluB;
    word_t aluResult;
    logic  aluCondition;
    word_t pcPlus4;
    word_t target;
    word_t nextPc;
    word_t wbData;

    registerFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .rs1Addr (ir[19:15]),
        .rs2Addr (ir[24:20]),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wr      (wbPort)
    );

    immediateGen immGen_i (
        .instr (ir),
        .kind  (ctrl.immKind),
        .imm   (imm)
    );

    alu alu_i (
        .a         (rs1Reg),
        .b         (aluB),
        .op        (ctrl.aluOp),
        .result    (aluResult),
        .condition (aluCondition)
    );

    assign aluB    = ctrl.aluSrcImm ? immReg : rs2Reg;
    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + immReg; // Branch and jal target

    always_comb begin
        case (ctrl.pcSel)
            PC_TARGET: nextPc = target;
            PC_ALU:    nextPc = {resultReg[31:1], 1'b0};
            default:   nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  wbData = memRData;
            WB_PC4:  wbData = pcPlus4;
            default: wbData = resultReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            ir          <= '0;
            branchTaken <= 1'b0;
        end else begin
            if (ctrl.irWrite) begin
                ir <= instrData;
            end
            if (ctrl.resultLoad) begin
                branchTaken <= aluCondition;
            end
            if (ctrl.pcWrite) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.operandLoad) begin
            rs1Reg <= rs1Data;
            rs2Reg <= rs2Data;
            immReg <= imm;
        end
        if (ctrl.resultLoad) begin
            resultReg <= aluResult;
        end
    end

    assign instrAddr = pc;
    assign instr     = ir;
    assign memAddr   = aluResult; // Load address is read at the EXECUTE edge
    assign memWData  = rs2Reg;
    assign memWrite  = ctrl.memWrite;

    assign wbPort.enable = ctrl.regWrite;
    assign wbPort.addr   = ir[11:7];
    assign wbPort.data   = wbData;

    assert property (@(posedge clk) disable iff (reset) ctrl.pcWrite |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop
    import cpuPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    output word_t     instrAddr,
    input  word_t     instrData,
    output regWrite_t wbPort,
    output word_t     retired
);

    control_t ctrl;
    word_t    instr;
    logic     branchTaken;
    word_t    memAddr;
    word_t    memWData;
    logic     memWrite;
    word_t    memRData;

    controlUnit control_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .branchTaken (branchTaken),
        .ctrl        (ctrl),
        .retired     (retired)
    );

    datapath datapath_i (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .instrData   (instrData),
        .instrAddr   (instrAddr),
        .instr       (instr),
        .branchTaken (branchTaken),
        .memAddr     (memAddr),
        .memWData    (memWData),
        .memWrite    (memWrite),
        .memRData    (memRData),
        .wbPort      (wbPort)
    );

    dataMemory dmem_i (
        .clk   (clk),
        .addr  (memAddr),
        .wData (memWData),
        .write (memWrite),
        .rData (memRData)
    );

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb
    import cpuPkg::*;
;

    localparam int NUM_TESTS   = 6;
    localparam int MAX_STEPS   = 24;
    // Four cycles per step and about six of reset per test with 3x headroom
    localparam int CYCLE_LIMIT = NUM_TESTS * (MAX_STEPS * 4 + 6) * 3;

    logic      clk;
    logic      reset;
    word_t     instrAddr;
    word_t     instrData = '0;
    regWrite_t wbPort;
    word_t     retired;

    word_t       prog [64];
    logic [6:0]  progLen;
    word_t       modelRegs [32];
    word_t       modelMem [256];
    word_t       modelPc;
    logic [31:0] lfsr = 32'hd3c2;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          cycleCount;

    cpuTop dut_i (
        .clk       (clk),
        .reset     (reset),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .wbPort    (wbPort),
        .retired   (retired)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        instrData <= prog[instrAddr[7:2]]; // Instruction memory model
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycleCount);
        $display("sim failed");
        $finish;
    end

    function automatic logic lfsrStep();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [11:0] lfsrBits(input int count);
        logic [11:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[10:0], lfsrStep()};
        end
        return value;
    endfunction

    function automatic word_t regOp(input logic [6:0] f7, input logic [2:0] f3,
                                    input regAddr_t rd, input regAddr_t rs1, input regAddr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t immOp(input logic [6:0] op, input logic [2:0] f3,
                                    input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t storeWord(input regAddr_t rs2, input regAddr_t rs1,
                                        input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branchIf(input logic [2:0] f3, input regAddr_t rs1,
                                       input regAddr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t jumpLink(input regAddr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input word_t ins);
        prog[progLen[5:0]] = ins;
        progLen = progLen + 7'd1;
    endtask

    task automatic clearProgram();
        foreach (prog[i]) begin
            prog[i] = '0; // Opcode 0 retires as a no-op
        end
        progLen = '0;
    endtask

    task automatic reportMismatch(input string signal, input word_t got, input word_t expected);
        errorCount++;
        $display("[FAIL] %0d ns %s = %h, expected %h", $time, signal, got, expected);
    endtask

    // RV32I reference for one instruction at modelPc
    task automatic modelStep(input word_t ins, output logic expEn, output regAddr_t expRd,
                             output word_t expData);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      opb;
        word_t      immI;
        word_t      immS;
        word_t      immB;
        word_t      immJ;
        word_t      addr;
        word_t      next;
        logic       take;
        opc  = ins[6:0];
        f3   = ins[14:12];
        a    = modelRegs[ins[19:15]];
        b    = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        opb  = (opc == OP_IMM) ? immI : b;
        expEn   = 1'b0;
        expRd   = ins[11:7];
        expData = '0;
        next    = modelPc + 32'd4;
        take    = 1'b0;
        case (opc)
            OP_REG, OP_IMM: begin
                expEn = 1'b1;
                case (f3)
                    3'd0:    expData = (opc == OP_REG && ins[30]) ? a - opb : a + opb;
                    3'd1:    expData = a << opb[4:0];
                    3'd2:    expData = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    3'd3:    expData = (a < opb) ? 32'd1 : 32'd0;
                    3'd4:    expData = a ^ opb;
                    3'd5:    expData = ins[30] ? word_t'($signed(a) >>> opb[4:0]) : a >> opb[4:0];
                    3'd6:    expData = a | opb;
                    default: expData = a & opb;
                endcase
            end
            OP_LOAD: begin
                addr = a + immI;
                if (f3 == 3'b010) begin
                    expEn   = 1'b1;
                    expData = modelMem[addr[9:2]];
                end
            end
            OP_STORE: begin
                addr = a + immS;
                if (f3 == 3'b010) begin
                    modelMem[addr[9:2]] = b;
                end
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next = modelPc + immB;
                end
            end
            OP_JAL: begin
                expEn   = 1'b1;
                expData = modelPc + 32'd4;
                next    = modelPc + immJ;
            end
            OP_JALR: begin
                expEn   = 1'b1;
                expData = modelPc + 32'd4;
                next    = (a + immI) & ~32'd1;
            end
            default: ;
        endcase
        if (expEn && expRd != 5'd0) begin
            modelRegs[expRd] = expData;
        end
        modelPc = next;
    endtask

    // Pulses reset and follows the program with the model until it runs off the end
    task automatic runProgram(input string name);
        word_t    endAddr;
        word_t    pc;
        word_t    expData;
        logic     expEn;
        regAddr_t expRd;
        logic     sawWrite;
        logic     stuck;
        int       cycles;
        int       steps;
        int       errorsBefore;
        errorsBefore = errorCount;
        endAddr      = {23'b0, progLen, 2'b00};
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
        steps   = 0;
        stuck   = 1'b0;
        reset   = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        if (instrAddr !== 32'd0) begin
            reportMismatch("instrAddr", instrAddr, 32'd0);
        end
        if (retired !== 32'd0) begin
            reportMismatch("retired", retired, 32'd0);
        end
        while (modelPc < endAddr && !stuck) begin
            if (instrAddr !== modelPc) begin
                reportMismatch("instrAddr", instrAddr, modelPc);
            end
            pc = modelPc;
            modelStep(prog[modelPc[7:2]], expEn, expRd, expData);
            sawWrite = 1'b0;
            cycles   = 0;
            while (retired == word_t'(steps) && !stuck) begin
                @(negedge clk);
                cycles++;
                if (wbPort.enable) begin
                    sawWrite = 1'b1;
                    if (!expEn) begin
                        errorCount++;
                        $display("unexpected register write to x%0d by instruction at %h",
                                 wbPort.addr, pc);
                    end else begin
                        if (wbPort.addr !== expRd) begin
                            reportMismatch("wbPort.addr", {27'b0, wbPort.addr}, {27'b0, expRd});
                        end
                        if (wbPort.data !== expData) begin
                            reportMismatch("wbPort.data", wbPort.data, expData);
                        end
                    end
                end
                if (cycles > 8) begin
                    stuck = 1'b1;
                    errorCount++;
                    $display("instruction at %h never retired", pc);
                end
            end
            steps++;
            if (!stuck) begin
                if (expEn && !sawWrite) begin
                    errorCount++;
                    $display("instruction at %h did not write x%0d", pc, expRd);
                end
                if (cycles != 4) begin
                    errorCount++;
                    $display("instruction at %h took %0d cycles instead of 4", pc, cycles);
                end
                if (retired !== word_t'(steps)) begin
                    reportMismatch("retired", retired, word_t'(steps));
                end
            end
        end
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok, %0d instructions", name, steps);
        end else begin
            failedTests++;
            $display("%s: FAILED with %0d errors", name, errorCount - errorsBefore);
        end
        reset = 1'b1; // Hold the core idle while the next program loads
    endtask

    task automatic countTest();
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd1));
        emit(32'h1234_50b7); // lui is not supported
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd1, 12'd1));
        emit(32'h0000_0000);
        emit(32'h0000_0073); // ecall
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd1, 12'd1));
        emit(immOp(OP_IMM, 3'd0, 5'd2, 5'd1, 12'hfff));
        emit(32'h0000_000f); // fence
        runProgram("count");
    endtask

    task automatic immediateTest();
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd0, 5'd2, 5'd0, lfsrBits(11) | 12'h800)); // Negative
        emit(immOp(OP_IMM, 3'd0, 5'd3, 5'd1, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd7, 5'd4, 5'd2, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd6, 5'd5, 5'd1, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd4, 5'd6, 5'd2, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd2, 5'd7, 5'd2, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd3, 5'd8, 5'd1, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd1, 5'd9, 5'd1, lfsrBits(5)));
        emit(immOp(OP_IMM, 3'd5, 5'd10, 5'd2, lfsrBits(5)));
        emit(immOp(OP_IMM, 3'd5, 5'd11, 5'd2, lfsrBits(5) | 12'h400));
        emit(immOp(OP_IMM, 3'd0, 5'd0, 5'd1, lfsrBits(12))); // Shown on port but x0 keeps zero
        emit(regOp(7'h00, 3'd0, 5'd12, 5'd0, 5'd1));
        runProgram("immediate");
    endtask

    task automatic registerTest();
        logic [2:0] f3List [10];
        logic [6:0] f7List [10];
        f3List = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        f7List = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20};
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd0, 5'd2, 5'd0, lfsrBits(11) | 12'h800));
        emit(immOp(OP_IMM, 3'd0, 5'd5, 5'd0, lfsrBits(12))); // Upper bits ignored as shift
        for (int i = 0; i < 10; i++) begin
            emit(regOp(f7List[i], f3List[i], regAddr_t'(6 + i), 5'd1, 5'd2));
        end
        for (int i = 5; i < 10; i++) begin
            emit(regOp(f7List[i], f3List[i], regAddr_t'(11 + i), 5'd2, 5'd5));
        end
        runProgram("register");
    endtask

    task automatic memoryTest();
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd10, 5'd0, 12'd64)); // Base address
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd1, 5'd1, 5'd1, 12'd11));
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd1, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd0, 5'd2, 5'd0, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd0, 5'd3, 5'd0, lfsrBits(12)));
        emit(immOp(OP_IMM, 3'd0, 5'd4, 5'd0, lfsrBits(12)));
        emit(storeWord(5'd1, 5'd10, 12'd0));
        emit(storeWord(5'd2, 5'd10, 12'd12));
        emit(storeWord(5'd3, 5'd10, 12'd40));
        emit(storeWord(5'd4, 5'd10, 12'hff0));
        emit(immOp(OP_LOAD, 3'd2, 5'd5, 5'd10, 12'd40));
        emit(immOp(OP_LOAD, 3'd2, 5'd6, 5'd10, 12'hff0));
        emit(immOp(OP_LOAD, 3'd2, 5'd7, 5'd10, 12'd0));
        emit(immOp(OP_LOAD, 3'd2, 5'd8, 5'd10, 12'd12));
        emit(storeWord(5'd4, 5'd10, 12'd0)); // Overwrite
        emit(immOp(OP_LOAD, 3'd2, 5'd9, 5'd10, 12'd0));
        runProgram("memory");
    endtask

    task automatic branchTest();
        logic [2:0] conds [12];
        regAddr_t   lhs [12];
        regAddr_t   rhs [12];
        // Taken then not taken for beq, bne, blt, bge, bltu, bgeu
        conds = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4, 3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
        lhs   = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
        rhs   = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
        emit(immOp(OP_IMM, 3'd0, 5'd2, 5'd0, 12'hffd));
        emit(immOp(OP_IMM, 3'd0, 5'd3, 5'd0, 12'd5));
        for (int i = 0; i < 12; i++) begin
            emit(branchIf(conds[i], lhs[i], rhs[i], 13'd8));
            emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1)); // Skipped when taken
        end
        runProgram("branch");
    endtask

    task automatic jumpTest();
        clearProgram();
        emit(immOp(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd24));
        emit(jumpLink(5'd5, 21'd12));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_JALR, 3'd0, 5'd6, 5'd1, 12'd8));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_JALR, 3'd0, 5'd7, 5'd1, 12'd13)); // Odd sum drops bit 0
        emit(jumpLink(5'd0, 21'd8));
        emit(immOp(OP_IMM, 3'd0, 5'd20, 5'd20, 12'd1));
        emit(immOp(OP_IMM, 3'd0, 5'd8, 5'd7, 12'd0));
        runProgram("jump");
    endtask

    initial begin
        reset       = 1'b1;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        progLen     = '0;
        foreach (modelMem[i]) begin
            modelMem[i] = '0;
        end
        countTest();
        immediateTest();
        registerTest();
        memoryTest();
        branchTest();
        jumpTest();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/cpuPkg.sv
source/alu.sv
source/registerFile.sv
source/immediateGen.sv
source/dataMemory.sv
control/controlUnit.sv
source/datapath.sv
source/cpuTop.sv
testbench/cpuTb.sv

//--- Makefile
TOP := cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
